// File: hw/fpga_msg_path.sv
`timescale 1ns/10ps
`default_nettype none

module fpga_msg_path (
  input  wire                              clk,
  input  wire                              arst_n,
  input  wire  [link_pkg::FPGA_MSG_W-1:0]  fpga_msg,
  input  wire                              fpga_msg_valid,
  input  wire                              rd_open,
  input  wire                              rd_rden,
  output logic                             fpga_msg_full,
  output logic [link_pkg::HOST_WORD_W-1:0] rd_data,
  output logic                             rd_empty
);

  logic [link_pkg::FPGA_MSG_W-1:0]   mem [link_pkg::FPGA_FIFO_DEPTH];
  logic [link_pkg::FPGA_MSG_W-1:0]   head;
  logic [link_pkg::FPGA_FIFO_AW-1:0] wr_ptr;
  logic [link_pkg::FPGA_FIFO_AW-1:0] rd_ptr;
  logic [link_pkg::FPGA_FIFO_AW:0]   count;
  logic                              half_sel;
  logic                              do_wr;
  logic                              do_step;
  logic                              do_pop;

  // Messages only enter while the host read stream is open
  assign do_wr = fpga_msg_valid && rd_open && !fpga_msg_full;

  // Each host read moves one word; the second one frees the entry
  assign do_step = rd_rden && !rd_empty;
  assign do_pop  = do_step && half_sel;

  assign rd_empty      = (count == '0);
  assign fpga_msg_full = count[link_pkg::FPGA_FIFO_AW];

  // **********************************************************************
  // Read side word select with low word first
  // **********************************************************************
  assign head    = mem[rd_ptr];
  assign rd_data = half_sel ? head[link_pkg::HOST_WORD_W +: link_pkg::HOST_WORD_W]
                            : head[link_pkg::HOST_WORD_W-1:0];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= fpga_msg;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      half_sel <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + (link_pkg::FPGA_FIFO_AW)'(1);
      end
      if (do_step) begin
        half_sel <= !half_sel;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + (link_pkg::FPGA_FIFO_AW)'(1);
      end
      case ({do_wr, do_pop})
        2'b10:   count <= count + (link_pkg::FPGA_FIFO_AW + 1)'(1);
        2'b01:   count <= count - (link_pkg::FPGA_FIFO_AW + 1)'(1);
        default: count <= count;
      endcase
    end
  end

  // Never left halfway through an entry once drained
  a_half_drained: assert property (@(posedge clk) disable iff (!arst_n)
    rd_empty |-> !half_sel)
    else $error("high word selected while empty");

endmodule

`default_nettype wire

// File: hw/host_link_top.sv
`timescale 1ns/10ps
`default_nettype none

module host_link_top (
  input  wire                                 clk,
  input  wire                                 arst_n,
  // Host write stream
  input  wire  [link_pkg::HOST_WORD_W-1:0]    wr_data,
  input  wire                                 wr_wren,
  input  wire                                 wr_open,
  output wire                                 wr_full,
  // Application intake
  input  wire                                 pc_msg_ack,
  output wire  [link_pkg::HOST_WORD_W-1:0]    pc_msg,
  output wire                                 pc_msg_pending,
  // Loopback stream
  input  wire                                 loop_rden,
  output wire  [link_pkg::HOST_WORD_W-1:0]    loop_data,
  output wire                                 loop_empty,
  output wire                                 loop_eof,
  // Application messages
  input  wire  [link_pkg::FPGA_MSG_W-1:0]     fpga_msg,
  input  wire                                 fpga_msg_valid,
  output wire                                 fpga_msg_full,
  // Host read stream
  input  wire                                 rd_open,
  input  wire                                 rd_rden,
  output wire  [link_pkg::HOST_WORD_W-1:0]    rd_data,
  output wire                                 rd_empty,
  output wire                                 rd_eof,
  // Application and memory status
  input  wire                                 app_done,
  input  wire                                 error,
  input  wire                                 phy_init_done,
  input  wire                                 app_rdy,
  input  wire                                 heartbeat,
  output wire  [status_pkg::STATUS_LED_W-1:0] status_led
);

  pc_msg_path u_pc_msg_path (
    .clk            (clk),
    .arst_n         (arst_n),
    .wr_data        (wr_data),
    .wr_wren        (wr_wren),
    .pc_msg_ack     (pc_msg_ack),
    .loop_rden      (loop_rden),
    .wr_full        (wr_full),
    .pc_msg         (pc_msg),
    .pc_msg_pending (pc_msg_pending),
    .loop_data      (loop_data),
    .loop_empty     (loop_empty)
  );

  fpga_msg_path u_fpga_msg_path (
    .clk            (clk),
    .arst_n         (arst_n),
    .fpga_msg       (fpga_msg),
    .fpga_msg_valid (fpga_msg_valid),
    .rd_open        (rd_open),
    .rd_rden        (rd_rden),
    .fpga_msg_full  (fpga_msg_full),
    .rd_data        (rd_data),
    .rd_empty       (rd_empty)
  );

  // Watches both paths for the end flags
  stream_end_ctrl u_stream_end_ctrl (
    .clk            (clk),
    .arst_n         (arst_n),
    .pc_msg         (pc_msg),
    .pc_msg_pending (pc_msg_pending),
    .rd_empty       (rd_empty),
    .loop_empty     (loop_empty),
    .wr_open        (wr_open),
    .rd_open        (rd_open),
    .app_done       (app_done),
    .error          (error),
    .phy_init_done  (phy_init_done),
    .app_rdy        (app_rdy),
    .heartbeat      (heartbeat),
    .rd_eof         (rd_eof),
    .loop_eof       (loop_eof),
    .status_led     (status_led)
  );

endmodule

`default_nettype wire

// File: hw/link_pkg.sv
`default_nettype none

package link_pkg;

  // **********************************************************************
  // Host stream data widths
  // **********************************************************************

  // One word on the host write, read and loopback streams
  localparam int HOST_WORD_W = 32;

  // Application message toward the host, sent as two host words
  localparam int FPGA_MSG_W = 64;

  // **********************************************************************
  // FIFO sizing
  // **********************************************************************

  // Host word FIFOs hold 16 entries
  localparam int HOST_FIFO_AW    = 4;
  localparam int HOST_FIFO_DEPTH = 1 << HOST_FIFO_AW;

  // Message FIFO holds 8 full messages
  localparam int FPGA_FIFO_AW    = 3;
  localparam int FPGA_FIFO_DEPTH = 1 << FPGA_FIFO_AW;

endpackage

`default_nettype wire

// File: hw/msg_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module msg_fifo (
  input  wire                              clk,
  input  wire                              arst_n,
  input  wire                              wr_en,
  input  wire  [link_pkg::HOST_WORD_W-1:0] din,
  input  wire                              rd_en,
  output logic [link_pkg::HOST_WORD_W-1:0] dout,
  output logic                             empty,
  output logic                             full
);

  logic [link_pkg::HOST_WORD_W-1:0]  mem [link_pkg::HOST_FIFO_DEPTH];
  logic [link_pkg::HOST_FIFO_AW-1:0] wr_ptr;
  logic [link_pkg::HOST_FIFO_AW-1:0] rd_ptr;
  logic [link_pkg::HOST_FIFO_AW:0]   count;
  logic                              do_wr;
  logic                              do_rd;

  // Writes into a full FIFO and reads from an empty one are dropped
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  assign empty = (count == '0);
  // Count tops out at the depth, so its MSB alone means full
  assign full  = count[link_pkg::HOST_FIFO_AW];

  // Show-ahead head word
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + (link_pkg::HOST_FIFO_AW)'(1);
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + (link_pkg::HOST_FIFO_AW)'(1);
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + (link_pkg::HOST_FIFO_AW + 1)'(1);
        2'b01:   count <= count - (link_pkg::HOST_FIFO_AW + 1)'(1);
        default: count <= count;
      endcase
    end
  end

  // Occupancy bound
  a_count_max: assert property (@(posedge clk) disable iff (!arst_n)
    count <= (link_pkg::HOST_FIFO_AW + 1)'(link_pkg::HOST_FIFO_DEPTH))
    else $error("msg_fifo count above depth");

  // Pointers meet when the FIFO is empty or full
  a_ptr_match: assert property (@(posedge clk) disable iff (!arst_n)
    (empty || full) |-> (wr_ptr == rd_ptr))
    else $error("msg_fifo pointers apart while empty or full");

endmodule

`default_nettype wire

// File: hw/pc_msg_path.sv
`timescale 1ns/10ps
`default_nettype none

module pc_msg_path (
  input  wire                              clk,
  input  wire                              arst_n,
  input  wire  [link_pkg::HOST_WORD_W-1:0] wr_data,
  input  wire                              wr_wren,
  input  wire                              pc_msg_ack,
  input  wire                              loop_rden,
  output wire                              wr_full,
  output wire  [link_pkg::HOST_WORD_W-1:0] pc_msg,
  output logic                             pc_msg_pending,
  output wire  [link_pkg::HOST_WORD_W-1:0] loop_data,
  output wire                              loop_empty
);

  logic wr_empty;
  logic loop_push;

  assign pc_msg_pending = !wr_empty;

  // Copy goes to loopback only for an ack that really pops a word
  assign loop_push = pc_msg_ack && pc_msg_pending;

  // **********************************************************************
  // Host words waiting for the application
  // **********************************************************************
  msg_fifo u_wr_fifo (
    .clk    (clk),
    .arst_n (arst_n),
    .wr_en  (wr_wren),
    .din    (wr_data),
    .rd_en  (pc_msg_ack),
    .dout   (pc_msg),
    .empty  (wr_empty),
    .full   (wr_full)
  );

  // **********************************************************************
  // Consumed words in consumption order, read back by the host
  // **********************************************************************
  // A copy arriving while full is lost inside the FIFO
  msg_fifo u_loop_fifo (
    .clk    (clk),
    .arst_n (arst_n),
    .wr_en  (loop_push),
    .din    (pc_msg),
    .rd_en  (loop_rden),
    .dout   (loop_data),
    .empty  (loop_empty),
    .full   ()
  );

  // Application acks only a pending message
  a_ack_pending: assert property (@(posedge clk) disable iff (!arst_n)
    pc_msg_ack |-> pc_msg_pending)
    else $error("pc_msg_ack without pending message");

endmodule

`default_nettype wire

// File: hw/status_pkg.sv
`default_nettype none

package status_pkg;

  // All-ones host word marks the end of host input
  localparam logic [link_pkg::HOST_WORD_W-1:0] EOS_WORD = '1;

  // **********************************************************************
  // Status LED layout
  // **********************************************************************

  localparam int STATUS_LED_W = 4;

  localparam int LED_HEARTBEAT = 0;
  localparam int LED_APP_RDY   = 1;
  localparam int LED_INIT_DONE = 2;
  localparam int LED_ERROR     = 3;

endpackage

`default_nettype wire

// File: hw/stream_end_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module stream_end_ctrl (
  input  wire                                clk,
  input  wire                                arst_n,
  input  wire  [link_pkg::HOST_WORD_W-1:0]   pc_msg,
  input  wire                                pc_msg_pending,
  input  wire                                rd_empty,
  input  wire                                loop_empty,
  input  wire                                wr_open,
  input  wire                                rd_open,
  input  wire                                app_done,
  input  wire                                error,
  input  wire                                phy_init_done,
  input  wire                                app_rdy,
  input  wire                                heartbeat,
  output logic                               rd_eof,
  output logic                               loop_eof,
  output logic [status_pkg::STATUS_LED_W-1:0] status_led
);

  logic eos_seen;
  logic rd_eof_set;

  // Sentinel at the head of the host queue with nothing left to send
  assign eos_seen   = pc_msg_pending && (pc_msg == status_pkg::EOS_WORD) && rd_empty;
  assign rd_eof_set = app_done || eos_seen;

  // **********************************************************************
  // End-of-stream flags
  // **********************************************************************
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_eof   <= 1'b0;
      loop_eof <= 1'b0;
    end else begin
      // Held until the host closes the read stream
      rd_eof   <= rd_open && (rd_eof || rd_eof_set);
      // Loopback ends once writes are closed and it has drained
      loop_eof <= !wr_open && loop_empty;
    end
  end

  // **********************************************************************
  // Status LEDs
  // **********************************************************************
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      status_led <= '0;
    end else begin
      status_led[status_pkg::LED_HEARTBEAT] <= heartbeat;
      status_led[status_pkg::LED_APP_RDY]   <= app_rdy;
      status_led[status_pkg::LED_INIT_DONE] <= phy_init_done;
      status_led[status_pkg::LED_ERROR]     <= error;
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module tb_host_link \
  -f sources.f \
  -o tb_host_link_sim

# Assertion stops end the run early and leave no pass line in the log
./obj_dir/tb_host_link_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: sim/tb_host_link.sv
`timescale 1ns/10ps
`default_nettype none

module tb_host_link;

  localparam int          CLK_PERIOD = 10;
  localparam logic [31:0] RAND_SEED  = 32'h285c_0478;

  // Cycle budget of each test
  localparam int RESET_CYCLES = 12;
  localparam int HOST_CYCLES  = 45;
  localparam int MSG_CYCLES   = 40;
  localparam int FULL_CYCLES  = 95;
  localparam int EOF_CYCLES   = 55;
  localparam int LED_CYCLES   = 25;
  localparam int TOTAL_CYCLES = RESET_CYCLES + HOST_CYCLES + MSG_CYCLES + FULL_CYCLES
                                + EOF_CYCLES + LED_CYCLES;

  // Strobe selectors
  localparam int S_WR   = 0;
  localparam int S_ACK  = 1;
  localparam int S_LOOP = 2;
  localparam int S_MSG  = 3;
  localparam int S_RD   = 4;

  logic                                clk;
  logic                                arst_n;
  logic [link_pkg::HOST_WORD_W-1:0]    wr_data;
  logic                                wr_wren;
  logic                                wr_open;
  logic                                pc_msg_ack;
  logic                                loop_rden;
  logic [link_pkg::FPGA_MSG_W-1:0]     fpga_msg;
  logic                                fpga_msg_valid;
  logic                                rd_open;
  logic                                rd_rden;
  logic                                app_done;
  logic                                error;
  logic                                phy_init_done;
  logic                                app_rdy;
  logic                                heartbeat;
  wire                                 wr_full;
  wire  [link_pkg::HOST_WORD_W-1:0]    pc_msg;
  wire                                 pc_msg_pending;
  wire  [link_pkg::HOST_WORD_W-1:0]    loop_data;
  wire                                 loop_empty;
  wire                                 loop_eof;
  wire                                 fpga_msg_full;
  wire  [link_pkg::HOST_WORD_W-1:0]    rd_data;
  wire                                 rd_empty;
  wire                                 rd_eof;
  wire  [status_pkg::STATUS_LED_W-1:0] status_led;

  // Reference model state
  logic [link_pkg::HOST_WORD_W-1:0]    wr_q[$];
  logic [link_pkg::HOST_WORD_W-1:0]    loop_q[$];
  logic [link_pkg::FPGA_MSG_W-1:0]     msg_q[$];
  logic                                m_half;
  logic                                m_rd_eof;
  logic                                m_loop_eof;
  logic [status_pkg::STATUS_LED_W-1:0] m_leds;
  int                                  err_count;
  int                                  check_count;

  host_link_top host_link_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // **********************************************************************
  // Reference functions and model
  // **********************************************************************

  // Host word of a message, low half first
  function automatic logic [31:0] msg_word(input logic [63:0] msg, input logic high);
    return high ? msg[63:32] : msg[31:0];
  endfunction

  function automatic logic [3:0] led_pattern(input logic err, input logic init,
                                             input logic rdy, input logic hb);
    logic [3:0] leds;
    leds = '0;
    leds[status_pkg::LED_ERROR]     = err;
    leds[status_pkg::LED_INIT_DONE] = init;
    leds[status_pkg::LED_APP_RDY]   = rdy;
    leds[status_pkg::LED_HEARTBEAT] = hb;
    return leds;
  endfunction

  // Steps with the DUT on each edge, from the inputs it samples there
  always @(posedge clk) begin : ref_model
    logic eos;
    logic wr_ok;
    logic ack_ok;
    logic push_ok;
    logic pop_ok;
    logic msg_ok;
    logic step_ok;
    if (!arst_n) begin
      wr_q.delete();
      loop_q.delete();
      msg_q.delete();
      m_half     = 1'b0;
      m_rd_eof   = 1'b0;
      m_loop_eof = 1'b0;
      m_leds     = '0;
    end else begin
      eos = (wr_q.size() > 0) && (wr_q[0] == status_pkg::EOS_WORD) && (msg_q.size() == 0);
      m_rd_eof   = rd_open && (m_rd_eof || app_done || eos);
      m_loop_eof = !wr_open && (loop_q.size() == 0);
      m_leds     = led_pattern(error, phy_init_done, app_rdy, heartbeat);
      // Full and empty decisions use the state before the edge
      wr_ok   = wr_wren && (wr_q.size() < link_pkg::HOST_FIFO_DEPTH);
      ack_ok  = pc_msg_ack && (wr_q.size() > 0);
      push_ok = ack_ok && (loop_q.size() < link_pkg::HOST_FIFO_DEPTH);
      pop_ok  = loop_rden && (loop_q.size() > 0);
      msg_ok  = fpga_msg_valid && rd_open && (msg_q.size() < link_pkg::FPGA_FIFO_DEPTH);
      step_ok = rd_rden && (msg_q.size() > 0);
      if (pop_ok) void'(loop_q.pop_front());
      if (push_ok) loop_q.push_back(wr_q[0]);
      if (ack_ok) void'(wr_q.pop_front());
      if (wr_ok) wr_q.push_back(wr_data);
      if (step_ok && m_half) void'(msg_q.pop_front());
      if (step_ok) m_half = !m_half;
      if (msg_ok) msg_q.push_back(fpga_msg);
    end
  end

  // **********************************************************************
  // Checking
  // **********************************************************************
  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clk) begin
    if (arst_n) begin
      check_val("pc_msg_pending", 64'(pc_msg_pending), 64'(wr_q.size() != 0));
      if (wr_q.size() != 0) check_val("pc_msg", 64'(pc_msg), 64'(wr_q[0]));
      check_val("wr_full", 64'(wr_full), 64'(wr_q.size() == link_pkg::HOST_FIFO_DEPTH));
      check_val("loop_empty", 64'(loop_empty), 64'(loop_q.size() == 0));
      if (loop_q.size() != 0) check_val("loop_data", 64'(loop_data), 64'(loop_q[0]));
      check_val("rd_empty", 64'(rd_empty), 64'(msg_q.size() == 0));
      if (msg_q.size() != 0) check_val("rd_data", 64'(rd_data), 64'(msg_word(msg_q[0], m_half)));
      check_val("fpga_msg_full", 64'(fpga_msg_full),
                64'(msg_q.size() == link_pkg::FPGA_FIFO_DEPTH));
      check_val("rd_eof", 64'(rd_eof), 64'(m_rd_eof));
      check_val("loop_eof", 64'(loop_eof), 64'(m_loop_eof));
      check_val("status_led", 64'(status_led), 64'(m_leds));
    end
  end

  // **********************************************************************
  // Stimulus
  // **********************************************************************
  task automatic idle(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic drive_strobe(input int sel, input logic on);
    case (sel)
      S_WR: begin
        wr_wren <= on;
        wr_data <= $urandom;
      end
      S_ACK:   pc_msg_ack <= on;
      S_LOOP:  loop_rden <= on;
      S_MSG: begin
        fpga_msg_valid <= on;
        fpga_msg       <= {$urandom, $urandom};
      end
      default: rd_rden <= on;
    endcase
  endtask

  // One strobe held for n cycles, new random data each cycle
  task automatic strobe_cycles(input int sel, input int n);
    repeat (n) begin
      @(posedge clk);
      drive_strobe(sel, 1'b1);
    end
    @(posedge clk);
    drive_strobe(sel, 1'b0);
  endtask

  task automatic host_words_in_order();
    strobe_cycles(S_WR, 10);
    idle(3);
    strobe_cycles(S_ACK, 10);
    idle(3);
    strobe_cycles(S_LOOP, 10);
    idle(3);
  endtask

  task automatic app_msgs_split();
    strobe_cycles(S_MSG, 5);
    @(posedge clk);
    rd_open <= 1'b0;
    strobe_cycles(S_MSG, 3);
    @(posedge clk);
    rd_open <= 1'b1;
    strobe_cycles(S_RD, 12);
    idle(3);
  endtask

  // Overflow of both FIFOs, one extra write each
  task automatic fill_both_fifos();
    strobe_cycles(S_WR, 17);
    idle(2);
    strobe_cycles(S_ACK, 16);
    strobe_cycles(S_LOOP, 16);
    strobe_cycles(S_MSG, 9);
    idle(2);
    strobe_cycles(S_RD, 18);
    idle(3);
  endtask

  task automatic end_flags();
    @(posedge clk);
    wr_wren <= 1'b1;
    wr_data <= status_pkg::EOS_WORD;
    @(posedge clk);
    wr_wren <= 1'b0;
    idle(5);
    rd_open <= 1'b0;
    idle(3);
    strobe_cycles(S_ACK, 1);
    rd_open <= 1'b1;
    idle(2);
    app_done <= 1'b1;
    @(posedge clk);
    app_done <= 1'b0;
    idle(5);
    rd_open <= 1'b0;
    idle(3);
    rd_open <= 1'b1;
    wr_open <= 1'b0;
    idle(3);
    strobe_cycles(S_LOOP, 1);
    idle(4);
    wr_open <= 1'b1;
    idle(3);
  endtask

  task automatic status_leds();
    repeat (20) begin
      @(posedge clk);
      error         <= 1'($urandom);
      phy_init_done <= 1'($urandom);
      app_rdy       <= 1'($urandom);
      heartbeat     <= 1'($urandom);
    end
    idle(3);
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    err_count      = 0;
    check_count    = 0;
    arst_n         <= 1'b0;
    wr_data        <= '0;
    wr_wren        <= 1'b0;
    wr_open        <= 1'b1;
    pc_msg_ack     <= 1'b0;
    loop_rden      <= 1'b0;
    fpga_msg       <= '0;
    fpga_msg_valid <= 1'b0;
    rd_open        <= 1'b1;
    rd_rden        <= 1'b0;
    app_done       <= 1'b0;
    error          <= 1'b0;
    phy_init_done  <= 1'b0;
    app_rdy        <= 1'b0;
    heartbeat      <= 1'b0;
    idle(10);
    arst_n <= 1'b1;
    idle(2);
    host_words_in_order();
    app_msgs_split();
    fill_both_fifos();
    end_flags();
    status_leds();
    $display("Checks run: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TOTAL_CYCLES * 4 * CLK_PERIOD);
    $display("Timeout: tests still running after %0d cycles", TOTAL_CYCLES * 4);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
hw/link_pkg.sv
hw/status_pkg.sv
hw/msg_fifo.sv
hw/pc_msg_path.sv
hw/fpga_msg_path.sv
hw/stream_end_ctrl.sv
hw/host_link_top.sv
sim/tb_host_link.sv
